//--- hdl/pci_lite_config.svh
/*
 * Build-time sizes for the shared-bus system.
 * ADDR_W and DATA_W must stay equal because the data phase reuses the address lines.
 * WORD_W must cover MEM_WORDS and sit below ID_LSB in the address.
 */
`ifndef PCI_LITE_CONFIG_SVH
`define PCI_LITE_CONFIG_SVH

// number of peer devices on the bus
`define NUM_DEV 3

`define ADDR_W 32       // multiplexed address/data lines
`define DATA_W 32       // memory word and read data

// per-target memory
`define MEM_WORDS 16
`define WORD_W 4        // word index in address bits 3..0

// device id field in address bits 11..8
`define ID_LSB 8
`define ID_W 4          // ids NUM_DEV..15 have no target

`endif

//--- hdl/pci_lite_pkg.sv
/*
 * Shared types for the bus system.
 * Widths come from pci_lite_config.svh.
 * CMD_READ is encoded as zero so an idle bus reads as a read command.
 */
`include "pci_lite_config.svh"

package pci_lite_pkg;

    // bus command on bus_cmd during the address phase
    typedef enum logic
    {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_t;

    // initiator sequencing
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,     // waiting for a strobe
        ST_REQ  = 2'd1,     // requesting the bus
        ST_ADDR = 2'd2,     // address phase
        ST_DATA = 2'd3      // data phase
    } init_state_t;

    // device number as it sits in the address id field
    typedef logic [`ID_W-1:0] dev_id_t;

    // word select inside one target memory
    typedef logic [`WORD_W-1:0] word_idx_t;

endpackage

//--- hdl/bus_arbiter.sv
/*
 * Fixed-priority arbiter and bus multiplexer. Highest device index wins.
 * grant is re-evaluated only on an idle bus and is kept while its owner still requests,
 * so a granted device never loses the bus before its address phase.
 * Target outputs are ORed and must be zero outside their own data phase.
 */
`timescale 1ns/1ps
`include "pci_lite_config.svh"

module bus_arbiter (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [`NUM_DEV-1:0]                  bus_req,
    input  logic [`NUM_DEV-1:0]                  frame_i,
    input  logic [`NUM_DEV-1:0]                  irdy_i,
    input  pci_lite_pkg::cmd_t [`NUM_DEV-1:0]    cmd_i,
    input  logic [`NUM_DEV-1:0][`ADDR_W-1:0]     ad_i,
    input  logic [`NUM_DEV-1:0]                  devsel_t,
    input  logic [`NUM_DEV-1:0]                  trdy_t,
    input  logic [`NUM_DEV-1:0][`DATA_W-1:0]     rdata_t,
    output logic [`NUM_DEV-1:0]                  grant,
    output logic                                 bus_frame,
    output logic                                 bus_irdy,
    output pci_lite_pkg::cmd_t                   bus_cmd,
    output logic [`ADDR_W-1:0]                   bus_ad,
    output logic                                 bus_devsel,
    output logic                                 bus_trdy,
    output logic [`DATA_W-1:0]                   bus_rdata
);
    import pci_lite_pkg::*;

    logic [`NUM_DEV-1:0] next_grant;    // one-hot pick among requesters
    logic                bus_idle;
    logic                owner_req;     // current owner has not started yet

    assign bus_idle  = !bus_frame && !bus_irdy;
    assign owner_req = |(grant & bus_req);

    // scan upward so the highest requester overwrites the lower ones
    always_comb
    begin
        next_grant = '0;
        for (int i = 0; i < `NUM_DEV; i++)
        begin
            if (bus_req[i])
            begin
                next_grant    = '0;
                next_grant[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            grant <= '0;
        else if (bus_idle && !owner_req)
            grant <= next_grant;        // zero when nobody asks
    end

    // owner's lines onto the bus, zeros with no owner
    always_comb
    begin
        bus_frame = 1'b0;
        bus_irdy  = 1'b0;
        bus_cmd   = CMD_READ;
        bus_ad    = '0;
        for (int i = 0; i < `NUM_DEV; i++)
        begin
            if (grant[i])
            begin
                bus_frame = frame_i[i];
                bus_irdy  = irdy_i[i];
                bus_cmd   = cmd_i[i];
                bus_ad    = ad_i[i];
            end
        end
    end

    // target responses are wired-OR
    assign bus_devsel = |devsel_t;
    assign bus_trdy   = |trdy_t;

    always_comb
    begin
        bus_rdata = '0;
        for (int i = 0; i < `NUM_DEV; i++)
            bus_rdata = bus_rdata | rdata_t[i];
    end

endmodule

//--- hdl/bus_initiator.sv
/*
 * Bus initiator for one device. req_valid is a one-cycle strobe taken only in ST_IDLE
 * and dropped otherwise. done pulses five clocks after the accepting edge on an idle bus.
 * done_err flags a master abort. rd_data is zero after a write or an abort.
 */
`timescale 1ns/1ps
`include "pci_lite_config.svh"

module bus_initiator (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [`ADDR_W-1:0]    req_addr,
    input  logic [`DATA_W-1:0]    req_wdata,
    input  logic                  grant,
    input  logic                  bus_devsel,
    input  logic [`DATA_W-1:0]    bus_rdata,
    output logic                  bus_req,
    output logic                  frame,
    output logic                  irdy,
    output pci_lite_pkg::cmd_t    cmd,
    output logic [`ADDR_W-1:0]    ad,
    output logic                  done,
    output logic                  done_err,
    output logic [`DATA_W-1:0]    rd_data
);
    import pci_lite_pkg::*;

    init_state_t         state;
    cmd_t                cmd_q;     // latched on the strobe
    logic [`ADDR_W-1:0]  addr_q;
    logic [`DATA_W-1:0]  wdata_q;
    logic                accept;

    assign accept = (state == ST_IDLE) && req_valid;    // busy strobes fall through

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= ST_IDLE;
            bus_req  <= 1'b0;
            done     <= 1'b0;
            done_err <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;                           // single-cycle pulse
            done_err <= 1'b0;
            bus_req  <= (state == ST_REQ) && !grant;    // low again once granted
            case (state)
                ST_IDLE:
                    if (accept)
                        state <= ST_REQ;
                ST_REQ:
                    if (grant)
                        state <= ST_ADDR;
                ST_ADDR:
                    state <= ST_DATA;
                ST_DATA:
                begin
                    state    <= ST_IDLE;
                    done     <= 1'b1;
                    done_err <= !bus_devsel;            // nobody claimed it
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // command payload and returned data
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd_q   <= req_write ? CMD_WRITE : CMD_READ;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        if (state == ST_DATA)
            rd_data <= (cmd_q == CMD_READ && bus_devsel) ? bus_rdata : '0;
    end

    assign frame = (state == ST_ADDR);
    assign irdy  = (state == ST_DATA);
    assign cmd   = cmd_q;

    // address first then write data on the same lines
    always_comb
    begin
        ad = '0;
        if (state == ST_ADDR)
            ad = addr_q;
        else if (state == ST_DATA && cmd_q == CMD_WRITE)
            ad = wdata_q;
    end

endmodule

//--- hdl/bus_target.sv
/*
 * Bus target with a reset-cleared word memory. Claims addresses whose id field
 * equals DEV_ID and always answers in the cycle after the address phase.
 * Address bits between the word index and the id field are ignored.
 */
`timescale 1ns/1ps
`include "pci_lite_config.svh"

module bus_target #(
    parameter pci_lite_pkg::dev_id_t DEV_ID = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  bus_frame,
    input  logic                  bus_irdy,
    input  pci_lite_pkg::cmd_t    bus_cmd,
    input  logic [`ADDR_W-1:0]    bus_ad,
    output logic                  devsel,
    output logic                  trdy,
    output logic [`DATA_W-1:0]    rdata
);
    import pci_lite_pkg::*;

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    logic               addr_phase;
    logic               id_match;
    word_idx_t          addr_idx;
    logic               hit_q;      // high only in our data phase
    logic               write_q;
    word_idx_t          idx_q;
    logic [`DATA_W-1:0] word_q;     // read ahead during address phase

    assign addr_phase = bus_frame && !bus_irdy;
    assign addr_idx   = bus_ad[`WORD_W-1:0];
    assign id_match   = (bus_ad[`ID_LSB +: `ID_W] == DEV_ID);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hit_q <= 1'b0;
            for (int w = 0; w < `MEM_WORDS; w++)
                mem[w] <= '0;
        end
        else
        begin
            hit_q <= addr_phase && id_match;
            if (hit_q && write_q && bus_irdy)
                mem[idx_q] <= bus_ad;   // write data rides on ad
        end
    end

    // decode payload
    always_ff @(posedge clk)
    begin
        if (addr_phase)
        begin
            write_q <= (bus_cmd == CMD_WRITE);
            idx_q   <= addr_idx;
            word_q  <= mem[addr_idx];
        end
    end

    assign devsel = hit_q;
    assign trdy   = hit_q && bus_irdy;                  // ready as soon as irdy shows
    assign rdata  = (hit_q && !write_q) ? word_q : '0;  // quiet unless reading

endmodule

//--- hdl/pci_lite_top.sv
/*
 * Shared-bus system top. One initiator and one target per device plus the arbiter.
 * Target i answers addresses whose id field is i.
 * All per-device ports are packed arrays indexed by device number.
 */
`timescale 1ns/1ps
`include "pci_lite_config.svh"

module pci_lite_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [`NUM_DEV-1:0]                req_valid,
    input  logic [`NUM_DEV-1:0]                req_write,
    input  logic [`NUM_DEV-1:0][`ADDR_W-1:0]   req_addr,
    input  logic [`NUM_DEV-1:0][`DATA_W-1:0]   req_wdata,
    output logic [`NUM_DEV-1:0]                done,
    output logic [`NUM_DEV-1:0]                done_err,
    output logic [`NUM_DEV-1:0][`DATA_W-1:0]   rd_data
);
    import pci_lite_pkg::*;

    // initiator side
    logic [`NUM_DEV-1:0]               bus_req;
    logic [`NUM_DEV-1:0]               frame;
    logic [`NUM_DEV-1:0]               irdy;
    cmd_t [`NUM_DEV-1:0]               cmd;
    logic [`NUM_DEV-1:0][`ADDR_W-1:0]  ad;
    logic [`NUM_DEV-1:0]               grant;

    // target side
    logic [`NUM_DEV-1:0]               devsel;
    logic [`NUM_DEV-1:0]               trdy;
    logic [`NUM_DEV-1:0][`DATA_W-1:0]  rdata;

    // shared bus
    logic                              bus_frame;
    logic                              bus_irdy;
    cmd_t                              bus_cmd;
    logic [`ADDR_W-1:0]                bus_ad;
    logic                              bus_devsel;
    logic                              bus_trdy;
    logic [`DATA_W-1:0]                bus_rdata;

    bus_arbiter u_arb (
        .clk        (clk),
        .arst_n     (arst_n),
        .bus_req    (bus_req),
        .frame_i    (frame),
        .irdy_i     (irdy),
        .cmd_i      (cmd),
        .ad_i       (ad),
        .devsel_t   (devsel),
        .trdy_t     (trdy),
        .rdata_t    (rdata),
        .grant      (grant),
        .bus_frame  (bus_frame),
        .bus_irdy   (bus_irdy),
        .bus_cmd    (bus_cmd),
        .bus_ad     (bus_ad),
        .bus_devsel (bus_devsel),
        .bus_trdy   (bus_trdy),
        .bus_rdata  (bus_rdata)
    );

    for (genvar g = 0; g < `NUM_DEV; g++)
    begin : g_dev
        bus_initiator u_init (
            .clk        (clk),
            .arst_n     (arst_n),
            .req_valid  (req_valid[g]),
            .req_write  (req_write[g]),
            .req_addr   (req_addr[g]),
            .req_wdata  (req_wdata[g]),
            .grant      (grant[g]),
            .bus_devsel (bus_devsel),
            .bus_rdata  (bus_rdata),
            .bus_req    (bus_req[g]),
            .frame      (frame[g]),
            .irdy       (irdy[g]),
            .cmd        (cmd[g]),
            .ad         (ad[g]),
            .done       (done[g]),
            .done_err   (done_err[g]),
            .rd_data    (rd_data[g])
        );

        bus_target #(.DEV_ID(dev_id_t'(g))) u_tgt (    // id equals slot number
            .clk       (clk),
            .arst_n    (arst_n),
            .bus_frame (bus_frame),
            .bus_irdy  (bus_irdy),
            .bus_cmd   (bus_cmd),
            .bus_ad    (bus_ad),
            .devsel    (devsel[g]),
            .trdy      (trdy[g]),
            .rdata     (rdata[g])
        );
    end

endmodule

//--- bench/pci_lite_assert.sv
/*
 * Bus protocol checks, bound into pci_lite_top.
 * Checks are off while arst_n is low.
 */
`timescale 1ns/1ps
`include "pci_lite_config.svh"

module pci_lite_assert (
    input logic                clk,
    input logic                arst_n,
    input logic [`NUM_DEV-1:0] grant,
    input logic [`NUM_DEV-1:0] frame,
    input logic                bus_frame,
    input logic                bus_irdy,
    input logic                bus_devsel,
    input logic                bus_trdy,
    input logic [`NUM_DEV-1:0] done,
    input logic [`NUM_DEV-1:0] done_err
);
    int err_count = 0;  // failed checks so far

    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant))
    else
    begin
        $error("grant not one-hot: %b", grant);
        err_count++;
    end

    // frame only from a granted owner
    a_frame_owner: assert property (@(posedge clk) disable iff (!arst_n)
                                    (frame & ~grant) == '0)
    else
    begin
        $error("frame %b raised without grant %b", frame, grant);
        err_count++;
    end

    a_data_follows: assert property (@(posedge clk) disable iff (!arst_n)
                                     (bus_frame && !bus_irdy) |=> (!bus_frame && bus_irdy))
    else
    begin
        $error("address phase not followed by a data phase");
        err_count++;
    end

    // claimed data phase is ready at once, no wait states
    a_trdy_claim: assert property (@(posedge clk) disable iff (!arst_n)
                                   bus_devsel |-> (bus_trdy && bus_irdy))
    else
    begin
        $error("devsel without trdy in a data phase");
        err_count++;
    end

    a_err_with_done: assert property (@(posedge clk) disable iff (!arst_n)
                                      (done_err & ~done) == '0)
    else
    begin
        $error("done_err without done: %b", done_err);
        err_count++;
    end

endmodule

bind pci_lite_top pci_lite_assert u_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .grant      (grant),
    .frame      (frame),
    .bus_frame  (bus_frame),
    .bus_irdy   (bus_irdy),
    .bus_devsel (bus_devsel),
    .bus_trdy   (bus_trdy),
    .done       (done),
    .done_err   (done_err)
);

//--- bench/pci_lite_tb.sv
/*
 * Directed testbench for the shared-bus system. Inputs change on the falling edge.
 * Expected memory contents come from a local model updated on every mapped write.
 * Assumes at least 3 devices and 16 words per target.
 */
`timescale 1ns/1ps
`include "pci_lite_config.svh"

module pci_lite_tb;
    import pci_lite_pkg::*;

    localparam int TIMEOUT = 40;        // cycles per wait
    typedef logic [$clog2(`NUM_DEV)-1:0] slot_t;

    logic                              clk;
    logic                              arst_n;
    logic [`NUM_DEV-1:0]               req_valid;
    logic [`NUM_DEV-1:0]               req_write;
    logic [`NUM_DEV-1:0][`ADDR_W-1:0]  req_addr;
    logic [`NUM_DEV-1:0][`DATA_W-1:0]  req_wdata;
    logic [`NUM_DEV-1:0]               done;
    logic [`NUM_DEV-1:0]               done_err;
    logic [`NUM_DEV-1:0][`DATA_W-1:0]  rd_data;

    logic [`DATA_W-1:0] model [`NUM_DEV][`MEM_WORDS];  // expected target memories
    logic [`DATA_W-1:0] last_rdata;
    logic               last_err;
    int                 last_latency;   // falling edges from accepting edge to done

    pci_lite_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .done      (done),
        .done_err  (done_err),
        .rd_data   (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_timeout(input string msg);
        $display("Timed out while waiting for %s", msg);
        stop_run();
    endtask

    // id field and word index, other bits zero
    function automatic logic [`ADDR_W-1:0] make_addr(input dev_id_t id, input word_idx_t w);
        logic [`ADDR_W-1:0] a;
        a = '0;
        a[`ID_LSB +: `ID_W] = id;
        a[`WORD_W-1:0] = w;
        return a;
    endfunction

    // called on a falling edge, returns one falling edge later
    task automatic drive_strobe(input slot_t d, input logic wr, input logic [`ADDR_W-1:0] addr,
                                input logic [`DATA_W-1:0] wdata);
        req_valid[d] = 1'b1;
        req_write[d] = wr;
        req_addr[d]  = addr;
        req_wdata[d] = wdata;
        @(negedge clk);
        req_valid[d] = 1'b0;
    endtask

    task automatic wait_done(input slot_t d);
        int cycles;
        cycles = 0;
        while (!done[d] && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done[d])
            report_timeout($sformatf("done on device %0d", d));
        last_latency = cycles;
        last_rdata   = rd_data[d];  // valid with done
        last_err     = done_err[d];
    endtask

    task automatic run_access(input slot_t d, input logic wr, input logic [`ADDR_W-1:0] addr,
                              input logic [`DATA_W-1:0] wdata);
        drive_strobe(d, wr, addr, wdata);
        wait_done(d);
    endtask

    task automatic reset_reads_zero();
        for (int i = 0; i < `NUM_DEV; i++)
        begin
            run_access(slot_t'(i), 1'b0, make_addr(dev_id_t'(i), '0), '0);
            assert (last_rdata == '0 && !last_err)
            else report_mismatch($sformatf("dev %0d word 0 after reset: %h err %b",
                                           i, last_rdata, last_err));
        end
    endtask

    // all writes from device 0, reads from the next slot up
    task automatic write_then_read_back();
        word_idx_t          w [`NUM_DEV];
        logic [`DATA_W-1:0] data;
        slot_t              s;
        for (int t = 0; t < `NUM_DEV; t++)
        begin
            s    = slot_t'(t);
            w[s] = word_idx_t'($urandom % `MEM_WORDS);
            data = $urandom;
            run_access('0, 1'b1, make_addr(dev_id_t'(t), w[s]), data);
            model[s][w[s]] = data;
            assert (!last_err && last_rdata == '0)
            else report_mismatch($sformatf("write to dev %0d: err %b rd_data %h",
                                           t, last_err, last_rdata));
        end
        for (int t = 0; t < `NUM_DEV; t++)
        begin
            s = slot_t'(t);
            run_access(slot_t'((t + 1) % `NUM_DEV), 1'b0, make_addr(dev_id_t'(t), w[s]), '0);
            assert (!last_err && last_rdata == model[s][w[s]])
            else report_mismatch($sformatf("dev %0d word %0d read %h expected %h",
                                           t, w[s], last_rdata, model[s][w[s]]));
        end
    endtask

    task automatic idle_bus_latency();
        word_idx_t w;
        slot_t     s;
        for (int i = 0; i < `NUM_DEV; i++)
        begin
            s = slot_t'(i);
            w = word_idx_t'($urandom % `MEM_WORDS);
            run_access(s, 1'b0, make_addr(dev_id_t'(i), w), '0);
            assert (last_latency == 5 && last_rdata == model[s][w])
            else report_mismatch($sformatf("dev %0d latency %0d expected 5, data %h",
                                           i, last_latency, last_rdata));
        end
    endtask

    task automatic unmapped_master_abort();
        word_idx_t w;
        slot_t     s;
        w = word_idx_t'($urandom % `MEM_WORDS);
        run_access(slot_t'(1), 1'b1, make_addr(dev_id_t'(15), w), $urandom);  // write to id 15
        assert (last_err && last_rdata == '0)
        else report_mismatch($sformatf("abort write: err %b rd_data %h", last_err, last_rdata));
        run_access(slot_t'(2), 1'b0, make_addr(dev_id_t'(`NUM_DEV), w), '0);  // first free id
        assert (last_err && last_rdata == '0)
        else report_mismatch($sformatf("abort read: err %b rd_data %h", last_err, last_rdata));
        for (int i = 0; i < `NUM_DEV; i++)
        begin
            s = slot_t'(i);
            run_access(s, 1'b0, make_addr(dev_id_t'(i), w), '0);
            assert (!last_err && last_rdata == model[s][w])
            else report_mismatch($sformatf("dev %0d word %0d changed to %h after abort",
                                           i, w, last_rdata));
        end
    endtask

    // devices 0 and 2 race for the same word in target 1
    task automatic priority_arbitration();
        word_idx_t          w;
        logic [`DATA_W-1:0] data0;
        logic [`DATA_W-1:0] data2;
        logic               seen0;
        logic               seen2;
        int                 cycles;
        w      = word_idx_t'($urandom % `MEM_WORDS);
        data0  = $urandom;
        data2  = ~data0;
        seen0  = 1'b0;
        seen2  = 1'b0;
        cycles = 0;
        req_write    = '1;
        req_addr[0]  = make_addr(dev_id_t'(1), w);
        req_addr[2]  = make_addr(dev_id_t'(1), w);
        req_wdata[0] = data0;
        req_wdata[2] = data2;
        req_valid[0] = 1'b1;
        req_valid[2] = 1'b1;
        @(negedge clk);
        req_valid = '0;
        while (!(seen0 && seen2) && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            if (done[0])    // checked first so a tie also fails
            begin
                assert (seen2 && !done_err[0])
                else report_mismatch("device 0 finished before device 2 or aborted");
                seen0 = 1'b1;
            end
            if (done[2])
            begin
                assert (!done_err[2]) else report_mismatch("device 2 write aborted");
                seen2 = 1'b1;
            end
        end
        if (!(seen0 && seen2))
            report_timeout("both competing writes to finish");
        model[1][w] = data0;    // device 0 wrote last
        run_access(slot_t'(2), 1'b0, make_addr(dev_id_t'(1), w), '0);
        assert (last_rdata == model[1][w])
        else report_mismatch($sformatf("contended word read %h expected %h",
                                       last_rdata, model[1][w]));
    endtask

    task automatic busy_strobe_ignored();
        word_idx_t          w;
        logic [`DATA_W-1:0] data_a;
        w      = word_idx_t'($urandom % `MEM_WORDS);
        data_a = $urandom;
        drive_strobe(slot_t'(1), 1'b1, make_addr(dev_id_t'(2), w), data_a);
        @(negedge clk);
        drive_strobe(slot_t'(1), 1'b1, make_addr(dev_id_t'(2), w), ~data_a);  // lands in ST_REQ
        wait_done(slot_t'(1));
        model[2][w] = data_a;
        for (int i = 0; i < 20; i++)
        begin
            @(negedge clk);
            assert (!done[1]) else report_mismatch("second done after an ignored strobe");
        end
        run_access('0, 1'b0, make_addr(dev_id_t'(2), w), '0);
        assert (last_rdata == model[2][w])
        else report_mismatch($sformatf("word holds %h expected %h", last_rdata, model[2][w]));
    endtask

    initial
    begin
        void'($urandom(56816));
        arst_n    = 1'b0;
        req_valid = '0;
        req_write = '0;
        req_addr  = '0;
        req_wdata = '0;
        model     = '{default: '0};
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        reset_reads_zero();
        write_then_read_back();
        idle_bus_latency();
        unmapped_master_abort();
        priority_arbitration();
        busy_strobe_ignored();
        if (dut0.u_chk.err_count == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            $display("Bus protocol assertions failed %0d times", dut0.u_chk.err_count);
            stop_run();
        end
    end

endmodule

//--- build.f
+incdir+hdl
hdl/pci_lite_pkg.sv
hdl/bus_arbiter.sv
hdl/bus_initiator.sv
hdl/bus_target.sv
hdl/pci_lite_top.sv
bench/pci_lite_assert.sv
bench/pci_lite_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator; exit status is 0 only on a pass.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module pci_lite_tb -o pci_lite_sim \
    > compile.log 2>&1 || { cat compile.log; echo "compile failed"; exit 1; }
./obj_dir/pci_lite_sim +verilator+error+limit+100 > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx '\*\*\* PASSED \*\*\*' sim.log && echo "run passed" || { echo "run failed"; exit 1; }
